// ==== all.f ====
dma_pkg.sv
burst_if.sv
burst_sequencer.sv
aw_channel.sv
w_channel.sv
b_channel.sv
dma_write.sv
tb_dma_write.sv

// ==== run.sh ====
#!/bin/sh
# Compile the DMA write testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dma_write -f all.f; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_dma_write)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

// ==== tb_dma_write.sv ====
`timescale 1ns/1ns

module tb_dma_write;

	logic M_AXI_ACLK;
	logic M_AXI_ARESETN;

	// DUT ports
	logic [dma_pkg::addr_width-1:0] m_axi_awaddr;
	logic [7:0] m_axi_awlen;
	logic [2:0] m_axi_awsize;
	logic [1:0] m_axi_awburst;
	logic [3:0] m_axi_awcache;
	logic m_axi_awvalid;
	logic m_axi_awready;
	logic [dma_pkg::data_width-1:0] m_axi_wdata;
	logic [dma_pkg::strb_width-1:0] m_axi_wstrb;
	logic m_axi_wlast;
	logic m_axi_wvalid;
	logic m_axi_wready;
	logic m_axi_bvalid;
	logic m_axi_bready;
	logic [dma_pkg::count_width-1:0] fifo_rd_count;
	logic fifo_valid;
	logic [dma_pkg::data_width-1:0] fifo_data;
	logic fifo_ren;
	logic burst_transaction_complete;
	logic trigger_interrupt;

	// Fill rate 0 stops, then one in eight, one in two and every cycle
	int fill_mode;
	bit aw_stall;
	bit w_stall;

	// FWFT FIFO model and memory slave state
	logic [dma_pkg::data_width-1:0] fifo_q[$];
	logic [dma_pkg::data_width-1:0] next_word;
	logic [31:0] lfsr;
	logic push;
	int b_delay;

	// Reference counts of accepted transfers
	logic [dma_pkg::data_width-1:0] exp_word;
	int beat_cnt;
	int aw_cnt;
	int last_cnt;
	int resp_cnt;
	bit pop_req;
	bit b_taken;

	int cycles;
	int errors;
	int test_num;
	int failed_tests;
	int test_base;

	dma_write u_dut (.*);

	always #4 M_AXI_ACLK = ~M_AXI_ACLK;

	// Galois LFSR stepped once per bit
	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return b;
	endfunction

	// True with odds of one in 2**n
	function automatic logic rand_hit(input int n);
		logic hit;
		hit = 1'b1;
		for (int i = 0; i < n; i++) begin
			hit = hit & take_bit();
		end
		return hit;
	endfunction

	// Address of the n-th burst in a window of eight slots
	function automatic logic [dma_pkg::addr_width-1:0] expected_addr(input int n);
		int slots;
		slots = dma_pkg::addr_span / dma_pkg::burst_bytes;
		return dma_pkg::base_addr + dma_pkg::addr_width'((n % slots) * dma_pkg::burst_bytes);
	endfunction

	task automatic value_error(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic rule_error(input string msg);
		errors++;
		$display("%s at %0t", msg, $time);
	endtask

	// Wait for n more write responses
	task automatic run_bursts(input int n);
		int target;
		target = resp_cnt + n;
		while (resp_cnt < target) begin
			@(posedge M_AXI_ACLK);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (errors == test_base) begin
			$display("test %0d %s: ok, %0d bursts done", test_num, name, resp_cnt);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", test_num, name, errors - test_base);
		end
		test_base = errors;
	endtask

	// FIFO and slave models drive all inputs on the falling edge
	initial begin
		lfsr = 32'ha868;
		next_word = '0;
		b_delay = 2;
		m_axi_awready = 1'b0;
		m_axi_wready = 1'b0;
		m_axi_bvalid = 1'b0;
		fifo_rd_count = '0;
		fifo_valid = 1'b0;
		fifo_data = '0;
		forever begin
			@(negedge M_AXI_ACLK);
			// Word read at the last rising edge leaves the FIFO
			if (pop_req) begin
				if (fifo_q.size() == 0) begin
					rule_error("FIFO read while empty");
				end else begin
					void'(fifo_q.pop_front());
				end
			end
			case (fill_mode)
				1: push = rand_hit(3);
				2: push = rand_hit(1);
				3: push = 1'b1;
				default: push = 1'b0;
			endcase
			if (push && fifo_q.size() < 256) begin
				fifo_q.push_back(next_word);
				next_word = next_word + 32'd1;
			end
			fifo_valid = fifo_q.size() > 0;
			fifo_data = fifo_valid ? fifo_q[0] : '0;
			fifo_rd_count = dma_pkg::count_width'(fifo_q.size());
			m_axi_awready = aw_stall ? take_bit() : 1'b1;
			m_axi_wready = w_stall ? take_bit() : 1'b1;
			// Response only after both address and last beat went through
			if (m_axi_bvalid) begin
				if (b_taken) begin
					m_axi_bvalid = 1'b0;
				end
			end else if (aw_cnt > resp_cnt && last_cnt > resp_cnt) begin
				if (b_delay == 0) begin
					m_axi_bvalid = 1'b1;
					b_delay = rand_hit(1) ? 3 : 1;
				end else begin
					b_delay--;
				end
			end
		end
	end

	// Counts of what the slave accepted
	always @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			exp_word <= '0;
			beat_cnt <= 0;
			aw_cnt <= 0;
			last_cnt <= 0;
			resp_cnt <= 0;
			pop_req <= 1'b0;
			b_taken <= 1'b0;
		end else begin
			pop_req <= fifo_ren;
			b_taken <= m_axi_bvalid && m_axi_bready;
			if (m_axi_wvalid && m_axi_wready) begin
				exp_word <= exp_word + 32'd1;
				beat_cnt <= (beat_cnt == dma_pkg::burst_len - 1) ? 0 : beat_cnt + 1;
				if (m_axi_wlast) begin
					last_cnt <= last_cnt + 1;
				end
			end
			if (m_axi_awvalid && m_axi_awready) begin
				aw_cnt <= aw_cnt + 1;
			end
			if (m_axi_bvalid && m_axi_bready) begin
				resp_cnt <= resp_cnt + 1;
			end
		end
	end

	// Run limit sized for twenty slow bursts
	always @(posedge M_AXI_ACLK) begin
		cycles <= cycles + 1;
		if (cycles == 20 * (dma_pkg::burst_len * 8 + 40)) begin
			$display("timeout after %0d cycles, bursts stopped completing", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	data_order: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_wvalid && m_axi_wready |-> m_axi_wdata == exp_word
	) else value_error("data beat out of FIFO order");

	wlast_place: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_wvalid && m_axi_wready |-> m_axi_wlast == (beat_cnt == dma_pkg::burst_len - 1)
	) else value_error("wlast on the wrong beat");

	addr_wrap: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_awvalid && m_axi_awready |-> m_axi_awaddr == expected_addr(aw_cnt)
	) else value_error("burst address off the expected slot");

	// INCR bursts of full-width beats into normal modifiable memory
	aw_shape: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_awvalid && m_axi_awready |->
			int'(m_axi_awlen) + 1 == dma_pkg::burst_len
			&& (1 << m_axi_awsize) == dma_pkg::strb_width
			&& m_axi_awburst == 2'b01 && m_axi_awcache == 4'b0010
	) else value_error("burst length, size, type or cache code wrong");

	w_strobe: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_wvalid && m_axi_wready |-> &m_axi_wstrb
	) else value_error("write strobes not all set");

	// Ready pulses once, one cycle after the response first shows up
	bready_timing: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_bready == ($past(m_axi_bvalid) && !$past(m_axi_bvalid, 2))
	) else value_error("bready not a single pulse after bvalid");

	// Issue sees the count one edge before awvalid rises
	start_level: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		$rose(m_axi_awvalid) |->
			$past(fifo_rd_count, 2) >= dma_pkg::count_width'(dma_pkg::start_threshold)
	) else value_error("burst started below the FIFO threshold");

	block_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		burst_transaction_complete == ($past(m_axi_bvalid && m_axi_bready)
			&& resp_cnt % dma_pkg::bursts_per_block == 0)
	) else value_error("block-complete pulse out of step");

	irq_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		trigger_interrupt == ($past(m_axi_bvalid && m_axi_bready)
			&& resp_cnt % dma_pkg::irq_bursts == 0)
	) else value_error("interrupt pulse out of step");

	aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr)
	) else rule_error("awvalid or awaddr changed before the address transfer");

	w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata)
	) else rule_error("wvalid or wdata changed before the data transfer");

	ren_on_beat: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		fifo_ren == (m_axi_wvalid && m_axi_wready)
	) else rule_error("FIFO read strobe not matching an accepted beat");

	initial begin
		M_AXI_ACLK = 1'b0;
		M_AXI_ARESETN = 1'b0;
		fill_mode = 0;
		aw_stall = 1'b0;
		w_stall = 1'b0;
		repeat (10) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
		@(posedge M_AXI_ACLK);
		fill_mode = 2;
		run_bursts(3);
		end_test("data order and wlast");
		// Past eight bursts so the offset wraps
		fill_mode = 3;
		run_bursts(7);
		end_test("address wrap");
		// Drain to below one burst and then trickle words in
		fill_mode = 0;
		while (fifo_rd_count >= dma_pkg::count_width'(dma_pkg::start_threshold)
				|| aw_cnt != resp_cnt || last_cnt != resp_cnt) begin
			@(posedge M_AXI_ACLK);
		end
		fill_mode = 1;
		run_bursts(2);
		end_test("start threshold");
		fill_mode = 3;
		run_bursts(4);
		end_test("block complete");
		run_bursts(6);
		end_test("interrupt");
		aw_stall = 1'b1;
		w_stall = 1'b1;
		fill_mode = 2;
		run_bursts(4);
		end_test("back-pressure");
		$display("%0d tests run, %0d failed, %0d errors", test_num, failed_tests, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== dma_write.sv ====
`timescale 1ns/1ns

module dma_write (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,

	// Write address channel
	output logic [dma_pkg::addr_width-1:0] m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,
	output logic [3:0] m_axi_awcache,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	// Write data channel
	output logic [dma_pkg::data_width-1:0] m_axi_wdata,
	output logic [dma_pkg::strb_width-1:0] m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	// Write response channel
	input logic m_axi_bvalid,
	output logic m_axi_bready,

	// FWFT source FIFO
	input logic [dma_pkg::count_width-1:0] fifo_rd_count,
	input logic fifo_valid,
	input logic [dma_pkg::data_width-1:0] fifo_data,
	output logic fifo_ren,

	// Status pulses
	output logic burst_transaction_complete,
	output logic trigger_interrupt
);

	// Issue and completion strobes
	burst_if u_bus ();

	// Every burst has the same shape
	assign m_axi_awlen = 8'(dma_pkg::burst_len - 1);
	assign m_axi_awsize = dma_pkg::awsize_code;
	assign m_axi_awburst = dma_pkg::awburst_incr;
	assign m_axi_awcache = dma_pkg::awcache_code;

	// Full, aligned beats only
	assign m_axi_wstrb = '1;

	burst_sequencer u_seq (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.fifo_rd_count(fifo_rd_count),
		.bus(u_bus.seq)
	);

	aw_channel u_aw (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.awready(m_axi_awready),
		.awvalid(m_axi_awvalid),
		.awaddr(m_axi_awaddr),
		.bus(u_bus.aw)
	);

	w_channel u_w (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.wready(m_axi_wready),
		.wvalid(m_axi_wvalid),
		.wdata(m_axi_wdata),
		.wlast(m_axi_wlast),
		.fifo_ren(fifo_ren),
		.bus(u_bus.w)
	);

	// Block and interrupt pulses come from the response side
	b_channel u_b (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.bvalid(m_axi_bvalid),
		.bready(m_axi_bready),
		.block_done(burst_transaction_complete),
		.irq(trigger_interrupt),
		.bus(u_bus.b)
	);

endmodule

// ==== b_channel.sv ====
`timescale 1ns/1ns

module b_channel (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic bvalid,
	output logic bready,
	output logic block_done,
	output logic irq,
	burst_if.b bus
);

	// Responses taken in the current block
	logic [dma_pkg::blk_cnt_width-1:0] blk_cnt;

	// Responses taken toward the next interrupt
	logic [dma_pkg::irq_cnt_width-1:0] irq_cnt;

	logic taken;
	logic blk_last;
	logic irq_last;

	assign taken = bvalid & bready;

	// Sequencer sees the response as soon as bready goes out
	assign bus.resp_done = bready;

	assign blk_last = blk_cnt == dma_pkg::blk_cnt_width'(dma_pkg::bursts_per_block - 1);
	assign irq_last = irq_cnt == dma_pkg::irq_cnt_width'(dma_pkg::irq_bursts - 1);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			bready <= 1'b0;
		end else begin
			// One-cycle ready a cycle after bvalid shows up
			bready <= bvalid & ~bready;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			blk_cnt <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= 1'b0;
			if (taken) begin
				// Fire and restart on the final burst of a block
				if (blk_last) begin
					blk_cnt <= '0;
					block_done <= 1'b1;
				end else begin
					blk_cnt <= blk_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			irq_cnt <= '0;
			irq <= 1'b0;
		end else begin
			irq <= 1'b0;
			if (taken) begin
				// Same scheme with the interrupt period
				if (irq_last) begin
					irq_cnt <= '0;
					irq <= 1'b1;
				end else begin
					irq_cnt <= irq_cnt + 1'b1;
				end
			end
		end
	end

	// Ready always meets a held response so resp_done marks a real take
	a_bready_on_bvalid: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		bready |-> bvalid
	);

endmodule

// ==== w_channel.sv ====
`timescale 1ns/1ns

module w_channel (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic fifo_valid,
	input logic [dma_pkg::data_width-1:0] fifo_data,
	input logic wready,
	output logic wvalid,
	output logic [dma_pkg::data_width-1:0] wdata,
	output logic wlast,
	output logic fifo_ren,
	burst_if.w bus
);

	// Data phase open, beats left in this burst
	logic active;

	// Index of the beat on the bus
	logic [dma_pkg::beat_idx_width-1:0] beat;

	logic last_beat;

	assign last_beat = beat == dma_pkg::beat_idx_width'(dma_pkg::burst_len - 1);

	// FWFT head word goes straight onto the bus
	assign wdata = fifo_data;
	assign wvalid = active & fifo_valid;

	// Last beat of the burst
	assign wlast = wvalid & last_beat;

	// Pop exactly the accepted beats
	assign fifo_ren = wvalid & wready;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			active <= 1'b0;
			beat <= '0;
			bus.data_done <= 1'b0;
		end else begin
			// Strobe follows the accepted last beat
			bus.data_done <= fifo_ren & last_beat;

			if (bus.issue) begin
				active <= 1'b1;
				beat <= '0;
			end else if (fifo_ren) begin
				// Counter wraps back to zero after the last beat
				beat <= beat + 1'b1;
				if (last_beat) begin
					active <= 1'b0;
				end
			end
		end
	end

	// Beat held while the slave stalls, the FIFO keeps its head word
	a_wvalid_hold: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		wvalid && !wready |=> wvalid
	);

	// Next burst never starts over a running data phase
	a_issue_when_quiet: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		bus.issue |-> !active
	);

endmodule

// ==== aw_channel.sv ====
`timescale 1ns/1ns

module aw_channel (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic awready,
	output logic awvalid,
	output logic [dma_pkg::addr_width-1:0] awaddr,
	burst_if.aw bus
);

	// Byte offset of the next burst inside the window
	logic [dma_pkg::addr_width-1:0] offset;

	logic aw_fire;
	logic last_slot;

	assign aw_fire = awvalid & awready;

	// Final burst slot of the address window
	assign last_slot = offset ==
		dma_pkg::addr_width'(dma_pkg::addr_span - dma_pkg::burst_bytes);

	// Base plus running offset
	assign awaddr = dma_pkg::base_addr + offset;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			awvalid <= 1'b0;
			bus.addr_done <= 1'b0;
			offset <= '0;
		end else begin
			// Report the handshake one cycle later
			bus.addr_done <= aw_fire;

			// Raise on issue and hold until the slave takes it
			if (bus.issue) begin
				awvalid <= 1'b1;
			end else if (aw_fire) begin
				awvalid <= 1'b0;
			end

			// Step one burst per accepted address
			if (aw_fire) begin
				if (last_slot) begin
					offset <= '0;
				end else begin
					offset <= offset + dma_pkg::addr_width'(dma_pkg::burst_bytes);
				end
			end
		end
	end

	// A new burst never lands on an address still waiting for awready
	a_issue_after_addr: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		bus.issue |-> !awvalid
	);

endmodule

// ==== burst_sequencer.sv ====
`timescale 1ns/1ns

module burst_sequencer (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic [dma_pkg::count_width-1:0] fifo_rd_count,
	burst_if.seq bus
);

	dma_pkg::seq_state_t state;

	// Done strobes seen since the last issue
	logic addr_seen;
	logic data_seen;

	logic fifo_ready;
	logic addr_any;
	logic both_done;

	// Enough words buffered for a whole burst
	assign fifo_ready = fifo_rd_count >= dma_pkg::count_width'(dma_pkg::start_threshold);

	// Include strobes arriving this cycle
	assign addr_any = addr_seen | bus.addr_done;
	assign both_done = addr_any & (data_seen | bus.data_done);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state <= dma_pkg::st_idle;
			bus.issue <= 1'b0;
			addr_seen <= 1'b0;
			data_seen <= 1'b0;
		end else begin
			// Issue is a single-cycle strobe
			bus.issue <= 1'b0;

			// Address and data may finish in either order
			if (bus.addr_done) begin
				addr_seen <= 1'b1;
			end
			if (bus.data_done) begin
				data_seen <= 1'b1;
			end

			case (state)
				dma_pkg::st_idle: begin
					// Only idle starts a burst so one is in flight at a time
					if (fifo_ready) begin
						bus.issue <= 1'b1;
						addr_seen <= 1'b0;
						data_seen <= 1'b0;
						state <= dma_pkg::st_addr;
					end
				end
				dma_pkg::st_addr: begin
					// Data can finish first under an address stall
					if (both_done) begin
						state <= dma_pkg::st_resp;
					end else if (addr_any) begin
						state <= dma_pkg::st_data;
					end
				end
				dma_pkg::st_data: begin
					// Address taken while beats still run
					if (both_done) begin
						state <= dma_pkg::st_resp;
					end
				end
				dma_pkg::st_resp: begin
					// Burst closes on the B handshake
					if (bus.resp_done) begin
						state <= dma_pkg::st_idle;
					end
				end
				default: begin
					state <= dma_pkg::st_idle;
				end
			endcase
		end
	end

	// Address and data strobes only come back for the open burst
	a_done_in_flight: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		bus.addr_done || bus.data_done |->
			state == dma_pkg::st_addr || state == dma_pkg::st_data
	);

	// Response strobe only once both halves of the burst are through
	a_resp_after_done: assert property (
		@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		bus.resp_done |-> state == dma_pkg::st_resp
	);

endmodule

// ==== burst_if.sv ====
`timescale 1ns/1ns

interface burst_if;

	// Start of a burst, one cycle
	logic issue;
	// Address handshake finished
	logic addr_done;
	// Last data beat accepted
	logic data_done;
	// Write response taken
	logic resp_done;

	// Sequencer starts bursts and watches the channels finish
	modport seq (
		output issue,
		input addr_done,
		input data_done,
		input resp_done
	);

	// Address channel
	modport aw (
		input issue,
		output addr_done
	);

	// Data channel
	modport w (
		input issue,
		output data_done
	);

	// Response channel runs on bvalid alone
	modport b (
		output resp_done
	);

endinterface

// ==== dma_pkg.sv ====
package dma_pkg;

	// AXI bus widths
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// Read count width of the source FIFO
	localparam int count_width = 10;

	// Burst geometry
	localparam int burst_len = 16;
	localparam int beat_idx_width = $clog2(burst_len);
	localparam int burst_bytes = burst_len * strb_width;

	// Target window, eight bursts before the offset wraps
	localparam logic [addr_width-1:0] base_addr = 32'h1000_0000;
	localparam int addr_span = 512;

	// A burst starts once this many words wait in the FIFO
	localparam int start_threshold = burst_len;

	// Completed bursts per status pulse
	localparam int bursts_per_block = 4;
	localparam int irq_bursts = 6;
	localparam int blk_cnt_width = $clog2(bursts_per_block);
	localparam int irq_cnt_width = $clog2(irq_bursts);

	// Fixed AXI attributes, full-width beats
	localparam logic [2:0] awsize_code = 3'($clog2(strb_width));
	// INCR
	localparam logic [1:0] awburst_incr = 2'b01;
	// Normal memory, non-bufferable, modifiable
	localparam logic [3:0] awcache_code = 4'b0010;

	// Sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data,
		st_resp
	} seq_state_t;

endpackage
